// File: data_store.sv
module data_store
	import dcache_pkg::*;
#(
	parameter int INDEX_BITS = 6
) (
	input  logic                  clk,
	input  logic [INDEX_BITS-1:0] index,
	input  logic                  rd_en,
	input  logic                  data_we,
	input  logic                  word_mode,   // merge one word into line_wdata
	input  line_t                 line_wdata,  // old line or fetched line
	input  word_sel_t             word_sel,
	input  word_t                 word_wdata,
	input  sel_t                  sel,
	output line_t                 line_rdata
);

	localparam int DEPTH = 1 << INDEX_BITS;

	line_t lines [DEPTH];  // contents are guarded by the tag valid bits
	line_t merged;         // line as it will be written

	// byte-lane merge of the cpu word into the selected word slot
	always_comb begin
		merged = line_wdata;
		if (word_mode) begin
			for (int b = 0; b < WORD_W / 8; b++) begin
				if (sel[b]) begin
					merged[word_sel * WORD_W + b * 8 +: 8] = word_wdata[b * 8 +: 8];
				end
			end
		end
	end

	// single port, write wins over read
	always_ff @(posedge clk) begin
		if (data_we) begin
			lines[index] <= merged;
			line_rdata   <= merged;  // written value visible next cycle
		end else if (rd_en) begin
			line_rdata <= lines[index];
		end
	end

endmodule

// File: dcache_ctrl.sv
module dcache_ctrl
	import dcache_pkg::*;
#(
	parameter int INDEX_BITS = 6
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  addr_t                 wb_adr,
	input  sel_t                  wb_sel,
	input  word_t                 wb_wdata,
	output word_t                 wb_rdata,
	output logic                  wb_ack,
	line_mem_if.master            mem,
	output logic [INDEX_BITS-1:0] index,
	output logic                  rd_en,
	output logic                  meta_we,
	output meta_t                 meta_wdata,
	output logic                  data_we,
	output logic                  word_mode,
	output line_t                 line_wdata,
	output word_sel_t             word_sel,
	output word_t                 word_wdata,
	output sel_t                  sel,
	input  meta_t                 meta_rdata,
	input  line_t                 line_rdata
);

	if (INDEX_BITS < MIN_INDEX_BITS || INDEX_BITS > MAX_INDEX_BITS) begin : g_index_range
		$error("dcache_ctrl: INDEX_BITS must be 4 to 8");
	end

	ctrl_state_t state;

	// request latched in IDLE
	addr_t req_adr;
	logic  req_we;
	sel_t  req_sel;
	word_t req_wdata;
	line_t fill_q;   // fetched line, written in REFILL

	tag_t       req_tag;
	logic       hit;
	logic       victim_dirty;
	line_addr_t fill_addr;
	line_addr_t victim_addr;

	assign index        = req_adr[OFFSET_BITS +: INDEX_BITS];
	assign req_tag      = addr_tag(req_adr, INDEX_BITS);
	assign hit          = meta_rdata[META_VALID] && (meta_rdata[TAG_W-1:0] == req_tag);
	assign victim_dirty = meta_rdata[META_VALID] && meta_rdata[META_DIRTY];
	assign fill_addr    = req_adr[ADDR_W-1:OFFSET_BITS];
	assign victim_addr  = line_addr_t'({meta_rdata[TAG_W-1:0], index});  // old tag + index

	assign word_sel   = req_adr[OFFSET_BITS-1 -: WORD_SEL_W];  // bits 3:2
	assign word_wdata = req_wdata;
	assign sel        = req_sel;
	assign wb_rdata   = line_rdata[word_sel * WORD_W +: WORD_W];
	assign mem.wdata  = line_rdata;  // stores sit idle while the victim goes out

	// store strobes and cpu ack, decoded from state
	always_comb begin
		rd_en      = (state == LOOKUP);
		wb_ack     = 1'b0;
		meta_we    = 1'b0;
		data_we    = 1'b0;
		word_mode  = req_we;
		meta_wdata = pack_meta(1'b1, req_we, req_tag);  // a write leaves the line dirty
		line_wdata = fill_q;
		case (state)
			COMPARE: begin
				if (hit) begin
					wb_ack = 1'b1;
					if (req_we) begin  // write hit merges into the line just read
						meta_we    = 1'b1;
						data_we    = 1'b1;
						line_wdata = line_rdata;
					end
				end
			end
			REFILL: begin
				meta_we = 1'b1;
				data_we = 1'b1;
			end
			default: ;
		endcase
	end

	// FSM and mem handshake
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= IDLE;
			mem.req <= 1'b0;
			mem.we  <= 1'b0;
		end else begin
			case (state)
				IDLE: if (wb_cyc && wb_stb) state <= LOOKUP;
				LOOKUP: state <= COMPARE;
				COMPARE: begin
					if (hit) begin
						state <= IDLE;
					end else if (victim_dirty) begin
						state   <= WRITE_BACK;
						mem.req <= 1'b1;
						mem.we  <= 1'b1;
					end else begin
						state   <= ALLOCATE;
						mem.req <= 1'b1;
					end
				end
				WRITE_BACK: begin
					if (mem.ack) begin  // req drops a cycle before the fill
						state   <= ALLOCATE;
						mem.req <= 1'b0;
						mem.we  <= 1'b0;
					end
				end
				ALLOCATE: begin
					if (mem.ack) begin
						state   <= REFILL;
						mem.req <= 1'b0;
					end else if (!mem.req) begin
						mem.req <= 1'b1;  // fill after a write-back
					end
				end
				REFILL: state <= LOOKUP;  // re-read, then COMPARE hits
				default: state <= IDLE;
			endcase
		end
	end

	// request, line address and fill payload
	always_ff @(posedge clk) begin
		if (state == IDLE && wb_cyc && wb_stb) begin
			req_adr   <= wb_adr;
			req_we    <= wb_we;
			req_sel   <= wb_sel;
			req_wdata <= wb_wdata;
		end
		if (state == COMPARE && !hit) mem.line_addr <= victim_dirty ? victim_addr : fill_addr;
		if (state == WRITE_BACK && mem.ack) mem.line_addr <= fill_addr;
		if (state == ALLOCATE && mem.ack) fill_q <= mem.rdata;
	end

	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (rst)
		wb_ack |-> wb_cyc && wb_stb
	) else $error("dcache_ctrl: ack outside a wishbone cycle");

	a_ack_single: assert property (
		@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack
	) else $error("dcache_ctrl: ack held for two cycles");

	a_mem_hold: assert property (
		@(posedge clk) disable iff (rst)
		mem.req && !mem.ack |=> mem.req && $stable(mem.we) && $stable(mem.line_addr)
			&& $stable(mem.wdata)
	) else $error("dcache_ctrl: line request changed before ack");

endmodule

// File: dcache_pkg.sv
package dcache_pkg;

	localparam int ADDR_W         = 32;
	localparam int WORD_W         = 32;
	localparam int WORDS_PER_LINE = 4;  // one line = one memory transfer
	localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
	localparam int OFFSET_BITS    = 4;  // byte offset inside a line
	localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);
	localparam int MIN_INDEX_BITS = 4;
	localparam int MAX_INDEX_BITS = 8;
	localparam int LINE_ADDR_W    = ADDR_W - OFFSET_BITS;

	// tag width is fixed by the widest index
	// for smaller indexes the top tag bits fall above the memory wrap and alias with it
	localparam int TAG_W      = ADDR_W - OFFSET_BITS - MAX_INDEX_BITS;
	localparam int META_W     = TAG_W + 2;
	localparam int META_VALID = META_W - 1;  // meta layout is {valid, dirty, tag}
	localparam int META_DIRTY = META_W - 2;

	typedef logic [ADDR_W-1:0]      addr_t;
	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [WORD_W/8-1:0]    sel_t;   // one bit per byte lane
	typedef logic [LINE_W-1:0]      line_t;
	typedef logic [WORD_SEL_W-1:0]  word_sel_t;
	typedef logic [TAG_W-1:0]       tag_t;
	typedef logic [META_W-1:0]      meta_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// memory power-up contents: each word holds its own byte address ^ INIT_XOR
	localparam word_t INIT_XOR = 32'h5a5a_0000;

	typedef enum logic [2:0] {
		IDLE, LOOKUP, COMPARE, WRITE_BACK, ALLOCATE, REFILL
	} ctrl_state_t;

	// upper address field above the index, truncated to tag_t
	function automatic tag_t addr_tag(addr_t adr, int unsigned index_bits);
		return tag_t'(adr >> (OFFSET_BITS + index_bits));
	endfunction

	function automatic meta_t pack_meta(logic valid, logic dirty, tag_t tag);
		return {valid, dirty, tag};
	endfunction

endpackage

// File: dcache_top.sv
module dcache_top
	import dcache_pkg::*;
#(
	parameter int INDEX_BITS    = 6,
	parameter int MEM_LATENCY   = 3,
	parameter int MEM_LINE_BITS = 10
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  wb_cyc,
	input  logic  wb_stb,
	input  logic  wb_we,
	input  addr_t wb_adr,
	input  sel_t  wb_sel,
	input  word_t wb_wdata,
	output word_t wb_rdata,
	output logic  wb_ack
);

	logic [INDEX_BITS-1:0] index;
	logic                  rd_en;
	logic                  meta_we;
	meta_t                 meta_wdata;
	meta_t                 meta_rdata;
	logic                  data_we;
	logic                  word_mode;
	line_t                 line_wdata;
	line_t                 line_rdata;
	word_sel_t             word_sel;
	word_t                 word_wdata;
	sel_t                  sel;

	line_mem_if mem_bus ();  // controller <-> backing memory

	dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
		.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_wdata,
		.wb_rdata, .wb_ack, .mem(mem_bus.master),
		.index, .rd_en, .meta_we, .meta_wdata, .data_we, .word_mode,
		.line_wdata, .word_sel, .word_wdata, .sel, .meta_rdata, .line_rdata
	);

	tag_store #(.INDEX_BITS(INDEX_BITS)) u_tags (
		.clk, .rst, .index, .rd_en, .meta_we, .meta_wdata, .meta_rdata
	);

	data_store #(.INDEX_BITS(INDEX_BITS)) u_data (
		.clk, .index, .rd_en, .data_we, .word_mode, .line_wdata,
		.word_sel, .word_wdata, .sel, .line_rdata
	);

	line_mem #(.MEM_LATENCY(MEM_LATENCY), .MEM_LINE_BITS(MEM_LINE_BITS)) u_mem (
		.clk, .rst, .mem(mem_bus.slave)
	);

endmodule

// File: flist.f
dcache_pkg.sv
line_mem_if.sv
tag_store.sv
data_store.sv
dcache_ctrl.sv
line_mem.sv
dcache_top.sv
tb_dcache.sv

// File: line_mem.sv
module line_mem
	import dcache_pkg::*;
#(
	parameter int MEM_LATENCY   = 3,
	parameter int MEM_LINE_BITS = 10
) (
	input logic       clk,
	input logic       rst,
	line_mem_if.slave mem
);

	if (MEM_LATENCY < 1) begin : g_latency_range
		$error("line_mem: MEM_LATENCY must be at least 1");
	end

	localparam int DEPTH = 1 << MEM_LINE_BITS;
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	line_t                   lines [DEPTH];
	logic                    busy;   // request accepted, counting down
	logic [CNT_W-1:0]        cnt;
	logic                    fire;   // last cycle before ack
	logic [MEM_LINE_BITS-1:0] row;   // line addresses wrap

	assign row  = mem.line_addr[MEM_LINE_BITS-1:0];
	assign fire = busy && (cnt == '0);

	// known pattern so that a cold miss is checkable
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			for (int w = 0; w < WORDS_PER_LINE; w++) begin
				lines[i][w * WORD_W +: WORD_W] =
					word_t'((i * WORDS_PER_LINE + w) * (WORD_W / 8)) ^ INIT_XOR;
			end
		end
	end

	// ack exactly MEM_LATENCY edges after req is first seen
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy    <= 1'b0;
			cnt     <= '0;
			mem.ack <= 1'b0;
		end else begin
			mem.ack <= fire;
			if (fire) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt - 1'b1;
			end else if (mem.req && !mem.ack) begin  // req still high in the ack cycle
				busy <= 1'b1;
				cnt  <= CNT_W'(MEM_LATENCY - 1);
			end
		end
	end

	always @(posedge clk) begin
		if (fire && mem.we) lines[row] <= mem.wdata;  // write lands with ack
	end

	always_ff @(posedge clk) begin
		if (fire && !mem.we) mem.rdata <= lines[row];
	end

	a_req_gap: assert property (
		@(posedge clk) disable iff (rst)
		mem.ack |=> !mem.req
	) else $error("line_mem: request not dropped after ack");

endmodule

// File: line_mem_if.sv
// line transfer channel between the cache controller and the backing memory
interface line_mem_if
	import dcache_pkg::*;
();

	logic       req;        // held until ack
	logic       we;         // 1 = write-back, 0 = fill
	line_addr_t line_addr;
	line_t      wdata;      // victim line
	line_t      rdata;      // valid with ack on a fill
	logic       ack;        // single cycle

	modport master (
		output req,
		output we,
		output line_addr,
		output wdata,
		input  rdata,
		input  ack
	);

	modport slave (
		input  req,
		input  we,
		input  line_addr,
		input  wdata,
		output rdata,
		output ack
	);

endinterface

// File: run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_dcache -f flist.f -o tb_dcache

out=$(./obj_dir/tb_dcache 2>&1 || true)
echo "$out"

if grep -q "TB PASSED" <<< "$out"; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1

// File: tag_store.sv
module tag_store
	import dcache_pkg::*;
#(
	parameter int INDEX_BITS = 6
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [INDEX_BITS-1:0] index,
	input  logic                  rd_en,
	input  logic                  meta_we,
	input  meta_t                 meta_wdata,
	output meta_t                 meta_rdata
);

	localparam int DEPTH = 1 << INDEX_BITS;

	logic [DEPTH-1:0]    valid_q;       // only the valid bits see reset
	logic [META_DIRTY:0] body [DEPTH];  // dirty + tag per index

	// valid bits and the output register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q    <= '0;
			meta_rdata <= '0;
		end else begin
			if (meta_we) begin
				valid_q[index] <= meta_wdata[META_VALID];
				meta_rdata     <= meta_wdata;  // write-through to the output
			end else if (rd_en) begin
				meta_rdata <= {valid_q[index], body[index]};
			end
		end
	end

	// dirty and tag bits
	always_ff @(posedge clk) begin
		if (meta_we) begin
			body[index] <= meta_wdata[META_DIRTY:0];
		end
	end

	// one port, so the controller must never read and write in one cycle
	a_no_rd_wr: assert property (
		@(posedge clk) disable iff (rst)
		!(rd_en && meta_we)
	) else $error("tag_store: read and write in the same cycle");

endmodule

// File: tb_dcache.sv
module tb_dcache
	import dcache_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int INDEX_BITS    = 6;
	localparam int MEM_LATENCY   = 3;
	localparam int MEM_LINE_BITS = 10;
	localparam int ADDR_SPAN     = 1 << (MEM_LINE_BITS + 4);  // bytes in the backing memory
	localparam int SET_STRIDE    = 1 << (INDEX_BITS + 4);     // same index, next tag
	localparam int RANDOM_OPS    = 300;
	localparam int MAX_ACCESSES  = 400;
	localparam int ACCESS_CYCLES = 2 * MEM_LATENCY + 10;      // dirty miss plus driver gaps
	localparam int TIMEOUT_CYCLES = 3 * MAX_ACCESSES * ACCESS_CYCLES + 800;
	localparam word_t INIT_PATTERN_XOR = 32'h5a5a_0000;

	logic  clk;
	logic  rst;
	logic  wb_cyc;
	logic  wb_stb;
	logic  wb_we;
	addr_t wb_adr;
	sel_t  wb_sel;
	word_t wb_wdata;
	word_t wb_rdata;
	logic  wb_ack;

	word_t model [addr_t];  // words written so far, keyed by word address
	word_t exp_rdata;       // expected data of the read in flight
	string test_name;
	logic  ack_prev;
	int    err_count;
	int    cycle_cnt;
	int    seed;

	dcache_top #(
		.INDEX_BITS(INDEX_BITS), .MEM_LATENCY(MEM_LATENCY), .MEM_LINE_BITS(MEM_LINE_BITS)
	) UUT (
		.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_wdata, .wb_rdata, .wb_ack
	);

	always #10 clk = ~clk;

	// wishbone byte lanes: sel[b] owns bits 8b+7..8b
	function automatic word_t merge_lanes(word_t old, word_t wdata, sel_t sel);
		word_t res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) res[b * 8 +: 8] = wdata[b * 8 +: 8];
		end
		return res;
	endfunction

	function automatic word_t ref_read(addr_t adr);
		addr_t wa;
		wa = adr & ~addr_t'(3);
		if (model.exists(wa)) return model[wa];
		return wa ^ INIT_PATTERN_XOR;  // untouched memory
	endfunction

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check_val(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			err_count++;
			abort_run();
		end
	endtask

	// one classic transfer; lat counts edges from the first stb sample to the ack sample
	task automatic run_transfer(logic we, addr_t adr, sel_t sel, word_t wdata, output int lat);
		@(negedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_sel   <= sel;
		wb_wdata <= wdata;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!wb_ack);
		@(negedge clk);  // ack taken at the edge in between
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(string name, addr_t adr, output int lat);
		test_name = name;
		exp_rdata = ref_read(adr);
		run_transfer(1'b0, adr, 4'hf, 32'h0, lat);
	endtask

	task automatic wb_write(string name, addr_t adr, sel_t sel, word_t wdata, output int lat);
		test_name = name;
		run_transfer(1'b1, adr, sel, wdata, lat);
		model[adr & ~addr_t'(3)] = merge_lanes(ref_read(adr), wdata, sel);
	endtask

	// compare process, every read ack plus the ack protocol
	always @(negedge clk) begin
		if (!rst) begin
			if (wb_ack && ack_prev) begin
				$display("ack stayed high for two cycles in %s", test_name);
				abort_run();
			end
			if (wb_ack && !(wb_cyc && wb_stb)) begin
				$display("ack arrived with no transfer active");
				abort_run();
			end
			if (wb_ack && !wb_we) begin
				check_val(test_name, exp_rdata, wb_rdata);
			end
		end
		ack_prev = wb_ack;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: no ack arrived within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	initial begin
		int    lat;
		addr_t a;
		addr_t b;
		logic  we;
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_sel = '0;
		wb_wdata = '0;
		ack_prev = 1'b0;
		err_count = 0;
		cycle_cnt = 0;
		seed = 32'ha928_bc32;
		repeat (2) @(negedge clk);
		rst <= 1'b0;

		// reset state, nothing may ack while idle
		repeat (5) begin
			@(negedge clk);
			check_val("idle ack after reset", 32'd0, 32'(wb_ack));
		end

		// cold miss then hit
		wb_read("cold read miss", 32'h0000_0100, lat);
		check_val("cold miss slower than hit", 32'd1, 32'(lat > 2));
		wb_read("read hit", 32'h0000_0100, lat);
		check_val("read hit latency", 32'd2, 32'(lat));

		// write hits with 0, 1, 2 and 4 lanes
		wb_write("write hit no lanes", 32'h0000_0104, 4'b0000, 32'hdead_beef, lat);
		check_val("write hit latency", 32'd2, 32'(lat));
		wb_read("merge no lanes", 32'h0000_0104, lat);
		wb_write("write hit one lane", 32'h0000_0104, 4'b0001, 32'h1122_3344, lat);
		wb_read("merge one lane", 32'h0000_0104, lat);
		wb_write("write hit two lanes", 32'h0000_0104, 4'b0110, 32'haabb_ccdd, lat);
		wb_read("merge two lanes", 32'h0000_0104, lat);
		wb_write("write hit four lanes", 32'h0000_0108, 4'b1111, 32'h0bad_f00d, lat);
		wb_read("merge four lanes", 32'h0000_0108, lat);

		// write-allocate, the rest of the line comes from memory
		wb_write("allocate write", 32'h0000_2004, 4'b1111, 32'hcafe_0001, lat);
		wb_read("allocate neighbour word", 32'h0000_2008, lat);
		wb_read("allocate written word", 32'h0000_2004, lat);

		// dirty eviction through write-back and refill
		a = 32'h0000_0340;
		b = a + addr_t'(SET_STRIDE);
		wb_write("evict write A", a, 4'b1111, 32'h5555_aaaa, lat);
		wb_read("evict read B", b, lat);
		wb_read("evict reread A", a, lat);
		wb_write("evict partial B", b + 4, 4'b1001, 32'h7788_9900, lat);
		wb_read("evict second A", a + 12, lat);
		wb_read("evict reread B", b + 4, lat);

		// random mix over the whole backing memory
		for (int i = 0; i < RANDOM_OPS; i++) begin
			a  = addr_t'($random(seed)) & addr_t'(ADDR_SPAN - 1) & ~addr_t'(3);
			we = 1'($random(seed));
			if (we) begin
				wb_write("random write", a, sel_t'($random(seed)), word_t'($random(seed)), lat);
			end else begin
				wb_read("random read", a, lat);
			end
		end

		repeat (3) @(negedge clk);
		if (err_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule
